// File: hw/itlb_pkg.sv
package itlb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // address and page widths
  ////////////////////////////////////////////////////////////////////////////

  // sv32 virtual page number, two 10-bit levels
  localparam int VPN_W         = 20;
  localparam int VPN_PART_W    = 10;
  // ppn sits in pte bits 29:10
  localparam int PPN_W         = 20;
  // upper ppn slice starts here
  localparam int PPN1_LSB      = 20;
  localparam int ADDR_W        = 32;
  localparam int PAGE_OFFSET_W = 12;
  // 4-byte pte, index to byte offset
  localparam int PTE_IDX_SHIFT = 2;

  ////////////////////////////////////////////////////////////////////////////
  // pte flag bits
  ////////////////////////////////////////////////////////////////////////////

  localparam int PTE_V  = 0;
  localparam int PTE_R  = 1;
  localparam int PTE_W  = 2;
  localparam int PTE_X  = 3;
  // perm field is {x, w, r}, same order as the pte
  localparam int PERM_W = 3;

  // tlb geometry
  localparam int TLB_ENTRIES = 8;
  localparam int TLB_IDX_W   = 3;

  // walker states
  typedef enum logic [2:0] {
    PTW_IDLE,
    PTW_LEVEL1,
    PTW_LEVEL0,
    PTW_FILL,
    PTW_RESP
  } ptw_state_e;

  // decoded pte class
  typedef enum logic [1:0] {
    PTE_POINTER,
    PTE_LEAF,
    PTE_FAULT
  } pte_kind_e;

endpackage

// File: hw/tlb_cam.sv
`timescale 1ns/10ps

module tlb_cam (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [itlb_pkg::VPN_W-1:0]     vpn,
  output logic                           hit,
  output logic [itlb_pkg::TLB_IDX_W-1:0] hit_idx,
  output logic [itlb_pkg::PPN_W-1:0]     hit_ppn,
  output logic [itlb_pkg::PERM_W-1:0]    hit_perm,
  input  logic                           fill_en,
  input  logic [itlb_pkg::TLB_IDX_W-1:0] fill_idx,
  input  logic [itlb_pkg::PPN_W-1:0]     fill_ppn,
  input  logic [itlb_pkg::PERM_W-1:0]    fill_perm
);
  import itlb_pkg::*;

  // entry state
  logic [TLB_ENTRIES-1:0] valid_q;
  logic [VPN_W-1:0]       tag_q  [TLB_ENTRIES];
  logic [PPN_W-1:0]       ppn_q  [TLB_ENTRIES];
  logic [PERM_W-1:0]      perm_q [TLB_ENTRIES];

  // one bit per entry, set on tag match
  logic [TLB_ENTRIES-1:0] match;

  ////////////////////////////////////////////////////////////////////////////
  // fill
  ////////////////////////////////////////////////////////////////////////////

  // valid bits, all cleared at reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // tag and translation payload
  // tag is the lookup vpn held during the walk
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_q[fill_idx]  <= vpn;
      ppn_q[fill_idx]  <= fill_ppn;
      perm_q[fill_idx] <= fill_perm;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // match
  ////////////////////////////////////////////////////////////////////////////

  // parallel compare against every entry
  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      match[i] = valid_q[i] && (tag_q[i] == vpn);
    end
  end

  assign hit = |match;

  // select the matching entry
  // at most one match, so priority order does not matter
  always_comb begin
    hit_idx  = '0;
    hit_ppn  = '0;
    hit_perm = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (match[i]) begin
        hit_idx  = TLB_IDX_W'(i);
        hit_ppn  = ppn_q[i];
        hit_perm = perm_q[i];
      end
    end
  end

  // fills only follow a miss, so no vpn can be cached twice
  a_single_match: assert property (
    @(posedge clk) disable iff (rst) $onehot0(match)
  );

endmodule

// File: hw/tlb_lru.sv
`timescale 1ns/10ps

module tlb_lru (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           touch,
  input  logic [itlb_pkg::TLB_IDX_W-1:0] touch_idx,
  output logic [itlb_pkg::TLB_IDX_W-1:0] victim_idx
);
  import itlb_pkg::*;

  // age per entry, 0 is most recent
  logic [TLB_IDX_W-1:0] age_q [TLB_ENTRIES];
  logic [TLB_IDX_W-1:0] touch_age;
  logic                 ages_ok;

  assign touch_age = age_q[touch_idx];

  // touched entry goes to 0
  // entries younger than it move back by one, older ones keep their age
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        age_q[i] <= TLB_IDX_W'(i);
      end
    end else if (touch) begin
      for (int i = 0; i < TLB_ENTRIES; i++) begin
        if (TLB_IDX_W'(i) == touch_idx) begin
          age_q[i] <= '0;
        end else if (age_q[i] < touch_age) begin
          age_q[i] <= age_q[i] + 1'b1;
        end
      end
    end
  end

  // victim is the oldest entry
  always_comb begin
    victim_idx = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (age_q[i] == TLB_IDX_W'(TLB_ENTRIES - 1)) begin
        victim_idx = TLB_IDX_W'(i);
      end
    end
  end

  // pairwise check, ages form a permutation
  always_comb begin
    ages_ok = 1'b1;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      for (int j = i + 1; j < TLB_ENTRIES; j++) begin
        if (age_q[i] == age_q[j]) begin
          ages_ok = 1'b0;
        end
      end
    end
  end

  // a duplicate age would leave no unique victim
  a_ages_distinct: assert property (@(posedge clk) disable iff (rst) ages_ok);

endmodule

// File: hw/ptw_fsm.sv
`timescale 1ns/10ps

module ptw_fsm (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  lookup_valid,
  output logic                  lookup_ready,
  input  logic                  cam_hit,
  input  logic                  mem_ack,
  input  itlb_pkg::pte_kind_e   pte_kind,
  output itlb_pkg::ptw_state_e  state,
  output logic                  lookup_accept,
  output logic                  mem_req,
  output logic                  fill_en,
  output logic                  touch,
  output logic                  resp_valid,
  output logic                  resp_fault
);
  import itlb_pkg::*;

  ptw_state_e state_d;

  // accepted lookup waiting for its cam check
  logic pend_q;
  // walk ended in a fault
  logic fault_q;
  logic fault_d;

  logic hit_resp;
  logic miss_start;

  ////////////////////////////////////////////////////////////////////////////
  // lookup handshake
  ////////////////////////////////////////////////////////////////////////////

  assign hit_resp   = (state == PTW_IDLE) && pend_q && cam_hit;
  assign miss_start = (state == PTW_IDLE) && pend_q && !cam_hit;

  // hits keep ready up so lookups can stream
  assign lookup_ready  = (state == PTW_IDLE) && !miss_start;
  assign lookup_accept = lookup_valid && lookup_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= lookup_accept;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // walker
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state;
    fault_d = fault_q;
    case (state)
      PTW_IDLE: begin
        fault_d = 1'b0;
        if (miss_start) begin
          state_d = PTW_LEVEL1;
        end
      end
      PTW_LEVEL1: begin
        if (mem_ack) begin
          case (pte_kind)
            PTE_POINTER: state_d = PTW_LEVEL0;
            PTE_LEAF:    state_d = PTW_FILL;
            default: begin
              state_d = PTW_RESP;
              fault_d = 1'b1;
            end
          endcase
        end
      end
      PTW_LEVEL0: begin
        // pointer at the last level is malformed
        if (mem_ack) begin
          if (pte_kind == PTE_LEAF) begin
            state_d = PTW_FILL;
          end else begin
            state_d = PTW_RESP;
            fault_d = 1'b1;
          end
        end
      end
      PTW_FILL: state_d = PTW_RESP;
      PTW_RESP: state_d = PTW_IDLE;
      default:  state_d = PTW_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= PTW_IDLE;
      fault_q <= 1'b0;
    end else begin
      state   <= state_d;
      fault_q <= fault_d;
    end
  end

  // outputs
  assign mem_req    = (state == PTW_LEVEL1) || (state == PTW_LEVEL0);
  assign fill_en    = (state == PTW_FILL);
  assign touch      = hit_resp || fill_en;
  // walk response reads the freshly filled entry
  assign resp_valid = hit_resp || (state == PTW_RESP);
  assign resp_fault = (state == PTW_RESP) && fault_q;

  // request held until the memory acknowledges it
  a_req_held: assert property (
    @(posedge clk) disable iff (rst) mem_req && !mem_ack |=> mem_req
  );

endmodule

// File: hw/ptw_datapath.sv
`timescale 1ns/10ps

module ptw_datapath (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          lookup_accept,
  input  logic [itlb_pkg::VPN_W-1:0]    lookup_vpn,
  input  itlb_pkg::ptw_state_e          state,
  input  logic                          mem_ack,
  input  logic [31:0]                   mem_rdata,
  input  logic [itlb_pkg::PPN_W-1:0]    satp_ppn,
  output logic [itlb_pkg::VPN_W-1:0]    vpn_q,
  output logic [itlb_pkg::ADDR_W-1:0]   mem_addr,
  output itlb_pkg::pte_kind_e           pte_kind,
  output logic [itlb_pkg::PPN_W-1:0]    fill_ppn,
  output logic [itlb_pkg::PERM_W-1:0]   fill_perm
);
  import itlb_pkg::*;

  logic [ADDR_W-1:0]     base_q;
  logic [ADDR_W-1:0]     table_base;
  logic [VPN_PART_W-1:0] vpn_slice;
  logic                  level0;
  logic                  pte_ack;

  // lookup vpn, held through cam check and walk
  always_ff @(posedge clk) begin
    if (rst) begin
      vpn_q <= '0;
    end else if (lookup_accept) begin
      vpn_q <= lookup_vpn;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pte address
  ////////////////////////////////////////////////////////////////////////////

  assign level0 = (state == PTW_LEVEL0);

  // root table from satp, second table from the pointer pte
  assign table_base = level0 ? base_q : {satp_ppn, {PAGE_OFFSET_W{1'b0}}};
  assign vpn_slice  = level0 ? vpn_q[VPN_PART_W-1:0] : vpn_q[VPN_W-1 -: VPN_PART_W];
  assign mem_addr   = table_base + (ADDR_W'(vpn_slice) << PTE_IDX_SHIFT);

  // pte decode
  always_comb begin
    if (!mem_rdata[PTE_V] || (mem_rdata[PTE_W] && !mem_rdata[PTE_R])) begin
      pte_kind = PTE_FAULT;
    end else if (!mem_rdata[PTE_R] && !mem_rdata[PTE_W] && !mem_rdata[PTE_X]) begin
      pte_kind = PTE_POINTER;
    end else begin
      pte_kind = PTE_LEAF;
    end
  end

  assign pte_ack = mem_ack && ((state == PTW_LEVEL1) || level0);

  // next-level base and fill data
  always_ff @(posedge clk) begin
    if (pte_ack && !level0 && (pte_kind == PTE_POINTER)) begin
      base_q <= {mem_rdata[PPN1_LSB-VPN_PART_W +: PPN_W], {PAGE_OFFSET_W{1'b0}}};
    end
    if (pte_ack && (pte_kind == PTE_LEAF)) begin
      fill_perm <= mem_rdata[PTE_X:PTE_R];
      // superpage keeps vpn bits 9:0 as the low ppn
      if (level0) begin
        fill_ppn <= mem_rdata[PPN1_LSB-VPN_PART_W +: PPN_W];
      end else begin
        fill_ppn <= {mem_rdata[PPN1_LSB +: PPN_W-VPN_PART_W], vpn_q[VPN_PART_W-1:0]};
      end
    end
  end

endmodule

// File: hw/itlb.sv
`timescale 1ns/10ps

module itlb (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        lookup_valid,
  input  logic [itlb_pkg::VPN_W-1:0]  lookup_vpn,
  output logic                        lookup_ready,
  input  logic [itlb_pkg::PPN_W-1:0]  satp_ppn,
  output logic                        resp_valid,
  output logic [itlb_pkg::PPN_W-1:0]  resp_ppn,
  output logic [itlb_pkg::PERM_W-1:0] resp_perm,
  output logic                        resp_fault,
  output logic                        mem_req,
  output logic [itlb_pkg::ADDR_W-1:0] mem_addr,
  input  logic                        mem_ack,
  input  logic [31:0]                 mem_rdata
);
  import itlb_pkg::*;

  // control
  ptw_state_e state;
  pte_kind_e  pte_kind;
  logic       lookup_accept;
  logic       fill_en;
  logic       touch;

  // cam side
  logic [VPN_W-1:0]     vpn_q;
  logic                 cam_hit;
  logic [TLB_IDX_W-1:0] hit_idx;
  logic [PPN_W-1:0]     hit_ppn;
  logic [PERM_W-1:0]    hit_perm;
  logic [PPN_W-1:0]     fill_ppn;
  logic [PERM_W-1:0]    fill_perm;

  // replacement
  logic [TLB_IDX_W-1:0] victim_idx;
  logic [TLB_IDX_W-1:0] touch_idx;

  ////////////////////////////////////////////////////////////////////////////
  // wiring
  ////////////////////////////////////////////////////////////////////////////

  // fill touches the victim, a hit touches the matching entry
  assign touch_idx = (state == PTW_FILL) ? victim_idx : hit_idx;

  // responses always come from the cam
  assign resp_ppn  = hit_ppn;
  assign resp_perm = hit_perm;

  ptw_fsm ptw_fsm_i (
    .clk           (clk),
    .rst           (rst),
    .lookup_valid  (lookup_valid),
    .lookup_ready  (lookup_ready),
    .cam_hit       (cam_hit),
    .mem_ack       (mem_ack),
    .pte_kind      (pte_kind),
    .state         (state),
    .lookup_accept (lookup_accept),
    .mem_req       (mem_req),
    .fill_en       (fill_en),
    .touch         (touch),
    .resp_valid    (resp_valid),
    .resp_fault    (resp_fault)
  );

  ptw_datapath ptw_datapath_i (
    .clk           (clk),
    .rst           (rst),
    .lookup_accept (lookup_accept),
    .lookup_vpn    (lookup_vpn),
    .state         (state),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .satp_ppn      (satp_ppn),
    .vpn_q         (vpn_q),
    .mem_addr      (mem_addr),
    .pte_kind      (pte_kind),
    .fill_ppn      (fill_ppn),
    .fill_perm     (fill_perm)
  );

  tlb_cam tlb_cam_i (
    .clk       (clk),
    .rst       (rst),
    .vpn       (vpn_q),
    .hit       (cam_hit),
    .hit_idx   (hit_idx),
    .hit_ppn   (hit_ppn),
    .hit_perm  (hit_perm),
    .fill_en   (fill_en),
    .fill_idx  (victim_idx),
    .fill_ppn  (fill_ppn),
    .fill_perm (fill_perm)
  );

  tlb_lru tlb_lru_i (
    .clk        (clk),
    .rst        (rst),
    .touch      (touch),
    .touch_idx  (touch_idx),
    .victim_idx (victim_idx)
  );

endmodule

// File: dv/itlb_tb.sv
`timescale 1ns/10ps

module itlb_tb;
  import itlb_pkg::*;

  localparam int N_VPN     = 16;
  // level-1 slots hold pointers 0..3, a superpage at 4, an invalid pte at 5 and a malformed one at 6
  localparam int N_L1      = 7;
  localparam int N_LOOKUPS = 400;
  localparam int RESET_CYC = 10;
  // worst lookup covers ready wait, accept, cam check, two reads of up to 4 cycles, fill, resp and gap
  localparam int LOOKUP_MAX  = 16;
  localparam int CYCLE_LIMIT = RESET_CYC + 2 + N_LOOKUPS * LOOKUP_MAX;
  localparam logic [PPN_W-1:0] ROOT_PPN = 20'h00080;
  localparam logic [PPN_W-1:0] L0_PPN   = 20'h00100;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 lookup_valid;
  logic [VPN_W-1:0]     lookup_vpn;
  logic                 lookup_ready;
  logic [PPN_W-1:0]     satp_ppn;
  logic                 resp_valid;
  logic [PPN_W-1:0]     resp_ppn;
  logic [PERM_W-1:0]    resp_perm;
  logic                 resp_fault;
  logic                 mem_req;
  logic [ADDR_W-1:0]    mem_addr;
  logic                 mem_ack;
  logic [31:0]          mem_rdata;

  integer seed;
  int     cycles = 0;

  // page table keyed by byte address
  logic [31:0]      pt_mem [logic [31:0]];
  logic [VPN_W-1:0] vpn_pool [N_VPN];
  logic [VPN_W-1:0] recent [$];

  // reference tlb and lru ages
  logic             m_valid [TLB_ENTRIES];
  logic [VPN_W-1:0] m_tag   [TLB_ENTRIES];
  logic [PPN_W-1:0] m_ppn   [TLB_ENTRIES];
  logic [PERM_W-1:0] m_perm [TLB_ENTRIES];
  int               m_age   [TLB_ENTRIES];

  // walk in flight as seen by the memory model
  logic [VPN_W-1:0] cur_vpn;
  int               reads_done;

  itlb dut_i (
    .clk          (clk),
    .rst          (rst),
    .lookup_valid (lookup_valid),
    .lookup_vpn   (lookup_vpn),
    .lookup_ready (lookup_ready),
    .satp_ppn     (satp_ppn),
    .resp_valid   (resp_valid),
    .resp_ppn     (resp_ppn),
    .resp_perm    (resp_perm),
    .resp_fault   (resp_fault),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run("timeout, the lookups did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // page table helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] pte_addr(input logic [PPN_W-1:0] base, input logic [9:0] idx);
    return {base, 12'h000} + {20'h0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] pte_at(input logic [31:0] addr);
    if (pt_mem.exists(addr)) begin
      return pt_mem[addr];
    end
    // unmapped reads as invalid
    return 32'h0;
  endfunction

  // fault beats pointer beats leaf
  function automatic pte_kind_e classify(input logic [31:0] pte);
    if (!pte[0] || (pte[2] && !pte[1])) begin
      return PTE_FAULT;
    end
    if (pte[3:1] == 3'b000) begin
      return PTE_POINTER;
    end
    return PTE_LEAF;
  endfunction

  // perm bits {x, w, r} never empty and never w without r
  function automatic logic [31:0] make_leaf(input logic [PPN_W-1:0] ppn, input logic [31:0] r);
    logic [PERM_W-1:0] perm;
    perm = r[2:0];
    if (perm == 3'b000) begin
      perm = 3'b100;
    end
    if (perm[1]) begin
      perm[0] = 1'b1;
    end
    return {2'b00, ppn, r[9:4], perm, 1'b1};
  endfunction

  task automatic build_table();
    logic [9:0]  l1 [N_L1];
    logic [31:0] r;
    logic [31:0] a0;
    int          li;
    for (int i = 0; i < N_L1; i++) begin
      l1[i] = 10'(i * 97 + 3);
      r = $random(seed);
      if (i < 4) begin
        pt_mem[pte_addr(ROOT_PPN, l1[i])] = {2'b00, L0_PPN + 20'(i), r[9:4], 4'b0001};
      end else if (i == 4) begin
        pt_mem[pte_addr(ROOT_PPN, l1[i])] = make_leaf(r[31:12], r);
      end else if (i == 5) begin
        pt_mem[pte_addr(ROOT_PPN, l1[i])] = {r[31:1], 1'b0};
      end else begin
        pt_mem[pte_addr(ROOT_PPN, l1[i])] = {2'b00, r[19:0], r[25:20], 4'b0101};
      end
    end
    // low bits carry k, so every vpn is distinct
    for (int k = 0; k < N_VPN; k++) begin
      r = $random(seed);
      li = k % N_L1;
      vpn_pool[k] = {l1[li], r[5:0], 4'(k)};
      if (li < 4) begin
        a0 = pte_addr(L0_PPN + 20'(li), vpn_pool[k][9:0]);
        if (k == 7) begin
          // pointer at level 0
          pt_mem[a0] = {2'b00, r[31:12], r[9:4], 4'b0001};
        end else if (k == 8) begin
          pt_mem[a0] = {r[31:1], 1'b0};
        end else begin
          pt_mem[a0] = make_leaf(r[31:12], r);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_walk(input logic [VPN_W-1:0] v, output logic fault,
                            output logic [PPN_W-1:0] ppn, output logic [PERM_W-1:0] perm,
                            output int nreads);
    logic [31:0] pte1;
    logic [31:0] pte0;
    pte1   = pte_at(pte_addr(ROOT_PPN, v[19:10]));
    nreads = 1;
    fault  = 1'b0;
    ppn    = '0;
    perm   = '0;
    case (classify(pte1))
      // superpage takes the low ppn from the vpn
      PTE_LEAF: begin
        ppn  = {pte1[29:20], v[9:0]};
        perm = pte1[3:1];
      end
      PTE_POINTER: begin
        nreads = 2;
        pte0 = pte_at(pte_addr(pte1[29:10], v[9:0]));
        if (classify(pte0) == PTE_LEAF) begin
          ppn  = pte0[29:10];
          perm = pte0[3:1];
        end else begin
          fault = 1'b1;
        end
      end
      default: fault = 1'b1;
    endcase
  endtask

  function automatic int model_find(input logic [VPN_W-1:0] v);
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (m_valid[i] && (m_tag[i] == v)) begin
        return i;
      end
    end
    return -1;
  endfunction

  // touched entry goes to 0 and younger ones age by one
  function automatic void model_touch(input int idx);
    int old;
    old = m_age[idx];
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (i == idx) begin
        m_age[i] = 0;
      end else if (m_age[i] < old) begin
        m_age[i] = m_age[i] + 1;
      end
    end
  endfunction

  function automatic int model_victim();
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (m_age[i] == TLB_ENTRIES - 1) begin
        return i;
      end
    end
    return 0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  // random ack delay of 0..3 cycles and address check against the walk
  initial begin
    logic        busy;
    int          wait_left;
    logic [31:0] expect_addr;
    logic [31:0] l1_pte;
    busy      = 1'b0;
    wait_left = 0;
    mem_ack   = 1'b0;
    mem_rdata = 32'h0;
    forever begin
      @(negedge clk);
      mem_ack   = 1'b0;
      // cycle-count garbage off the ack cycle
      mem_rdata = 32'(cycles) * 32'h9e37_79b9;
      if (rst || !mem_req) begin
        busy = 1'b0;
      end else begin
        if (!busy) begin
          busy      = 1'b1;
          wait_left = $random(seed) & 3;
          if (reads_done >= 2) begin
            abort_run("walker issued a third memory read in one walk");
          end
          l1_pte = pte_at(pte_addr(ROOT_PPN, cur_vpn[19:10]));
          if (reads_done == 0) begin
            expect_addr = pte_addr(ROOT_PPN, cur_vpn[19:10]);
          end else begin
            expect_addr = pte_addr(l1_pte[29:10], cur_vpn[9:0]);
          end
        end
        // also covers stability while the ack is delayed
        check("mem_addr", expect_addr, mem_addr);
        if (wait_left == 0) begin
          mem_ack    = 1'b1;
          mem_rdata  = pte_at(expect_addr);
          reads_done = reads_done + 1;
          busy       = 1'b0;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // mostly repeats of recent vpns and some from the whole pool
  function automatic logic [VPN_W-1:0] pick_vpn();
    logic [31:0] r;
    int          pos;
    r = $random(seed);
    if ((recent.size() > 0) && (r[1:0] != 2'b00)) begin
      pos = int'(r[9:4]) % recent.size();
      return recent[pos];
    end
    return vpn_pool[r[13:10]];
  endfunction

  // starts and ends on a falling edge
  task automatic do_lookup(input logic [VPN_W-1:0] v);
    int                idx;
    int                victim;
    int                exp_reads;
    logic              exp_fault;
    logic [PPN_W-1:0]  exp_ppn;
    logic [PERM_W-1:0] exp_perm;
    while (!lookup_ready) begin
      @(negedge clk);
    end
    cur_vpn      = v;
    reads_done   = 0;
    lookup_valid = 1'b1;
    lookup_vpn   = v;
    @(negedge clk);
    // accepted on the last edge so the vpn must now be ignored
    lookup_valid = 1'b0;
    lookup_vpn   = 20'($random(seed));
    idx = model_find(v);
    if (idx >= 0) begin
      check("hit_resp_valid", 32'd1, 32'(resp_valid));
      check("hit_mem_req", 32'd0, 32'(mem_req));
      check("hit_lookup_ready", 32'd1, 32'(lookup_ready));
      check("hit_resp_fault", 32'd0, 32'(resp_fault));
      check("hit_resp_ppn", 32'(m_ppn[idx]), 32'(resp_ppn));
      check("hit_resp_perm", 32'(m_perm[idx]), 32'(resp_perm));
      model_touch(idx);
    end else begin
      check("miss_resp_valid", 32'd0, 32'(resp_valid));
      check("miss_lookup_ready", 32'd0, 32'(lookup_ready));
      check("miss_mem_req", 32'd0, 32'(mem_req));
      model_walk(v, exp_fault, exp_ppn, exp_perm, exp_reads);
      @(negedge clk);
      while (!resp_valid) begin
        @(negedge clk);
      end
      check("walk_resp_fault", 32'(exp_fault), 32'(resp_fault));
      check("walk_read_count", 32'(exp_reads), 32'(reads_done));
      // faults leave the tlb untouched
      if (!exp_fault) begin
        check("walk_resp_ppn", 32'(exp_ppn), 32'(resp_ppn));
        check("walk_resp_perm", 32'(exp_perm), 32'(resp_perm));
        victim = model_victim();
        m_valid[victim] = 1'b1;
        m_tag[victim]   = v;
        m_ppn[victim]   = exp_ppn;
        m_perm[victim]  = exp_perm;
        model_touch(victim);
      end
    end
  endtask

  initial begin
    logic [VPN_W-1:0] v;
    seed         = 63;
    rst          = 1'b1;
    lookup_valid = 1'b0;
    lookup_vpn   = '0;
    satp_ppn     = ROOT_PPN;
    cur_vpn      = '0;
    reads_done   = 0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
      m_ppn[i]   = '0;
      m_perm[i]  = '0;
      m_age[i]   = i;
    end
    build_table();
    repeat (RESET_CYC) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("reset_lookup_ready", 32'd1, 32'(lookup_ready));
    check("reset_resp_valid", 32'd0, 32'(resp_valid));
    check("reset_mem_req", 32'd0, 32'(mem_req));
    for (int n = 0; n < N_LOOKUPS; n++) begin
      v = pick_vpn();
      do_lookup(v);
      recent.push_back(v);
      if (recent.size() > 6) begin
        void'(recent.pop_front());
      end
      // occasional idle cycle so hits mostly stream
      if (($random(seed) & 3) == 0) begin
        @(negedge clk);
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: itlb.f
hw/itlb_pkg.sv
hw/tlb_cam.sv
hw/tlb_lru.sv
hw/ptw_fsm.sv
hw/ptw_datapath.sv
hw/itlb.sv
dv/itlb_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = itlb_tb
FILELIST  = itlb.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
